// File: list.f
rtl/road_pkg.sv
rtl/road_ram.sv
rtl/road_line_seq.sv
rtl/road_rom_shifter.sv
rtl/road_mixer.sv
rtl/road_top.sv
tb/road_rom_model.sv
tb/road_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module road_tb -Mdir obj_dir -o road_sim

run: compile
	@out="$$(./obj_dir/road_sim)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb/road_tb.sv
`timescale 1ns/1ps

module road_tb;

    localparam int HS_PX   = 8;
    localparam int LINE_PX = 320;
    localparam int N_LINES = 16;
    // blank plus visible strobes of four clks per line, with room for CPU setup
    localparam longint WD_NS = (N_LINES * (HS_PX + LINE_PX + 40) * 4 + 2000) * 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen = 1'b0;
    logic [1:0]  cen_cnt = 2'd0;
    logic [8:0]  v;
    logic        vint, hs;
    logic [11:1] cpu_addr;
    logic [15:0] cpu_dout, cpu_din;
    logic [1:0]  cpu_dswn;
    logic        road_cs, io_cs, ram_half;
    logic [13:0] rom0_addr, rom1_addr;
    logic [15:0] rom0_data, rom1_data;
    logic        rom0_cs, rom1_cs, rom0_ok, rom1_ok;
    logic [7:0]  pxl;
    logic [4:3]  rc;

    // what the current line should show
    logic [11:0] e_idx [2];
    logic [11:0] e_scr [2];
    logic [11:0] e_col [2];
    road_pkg::road_mode_t e_mode;
    logic        line_on = 1'b0;
    logic        half_exp = 1'b0;

    // shifter model and the pixel expected after the next strobe
    logic [11:0] m_pos [2];
    logic [15:0] m_sh [2];
    logic        m_cent [2];
    logic        m_cs [2];
    logic        pend = 1'b0;
    logic [9:0]  pend_exp;
    int          errors = 0;

    road_top UUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .v(v), .vint(vint), .hs(hs),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
        .cpu_dswn(cpu_dswn), .road_cs(road_cs), .io_cs(io_cs), .ram_half(ram_half),
        .rom0_addr(rom0_addr), .rom0_data(rom0_data), .rom0_cs(rom0_cs), .rom0_ok(rom0_ok),
        .rom1_addr(rom1_addr), .rom1_data(rom1_data), .rom1_cs(rom1_cs), .rom1_ok(rom1_ok),
        .pxl(pxl), .rc(rc)
    );

    road_rom_model u_rom0 (.clk(clk), .addr(rom0_addr), .cs(rom0_cs), .data(rom0_data), .ok(rom0_ok));
    road_rom_model u_rom1 (.clk(clk), .addr(rom1_addr), .cs(rom1_cs), .data(rom1_data), .ok(rom1_ok));

    always #20 clk = ~clk;

    // pixel strobe on every 4th clk
    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        pxl_cen <= cen_cnt == 2'd2;
    end

    task automatic abort_run();
        errors++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input logic [15:0] want, input logic [15:0] got);
        if (got !== want) begin
            $display("FAIL cpu_din expected %h got %h", want, got);
            abort_run();
        end
    endtask

    task automatic check_pixel(input logic [7:0] want, input logic [7:0] got);
        if (got !== want) begin
            $display("FAIL pxl expected %h got %h", want, got);
            abort_run();
        end
    endtask

    task automatic check_rc(input logic [4:3] want, input logic [4:3] got);
        if (got !== want) begin
            $display("FAIL rc expected %h got %h", want, got);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [13:0] want, input logic [13:0] got);
        if (got !== want) begin
            $display("FAIL %s expected %h got %h", name, want, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("FAIL %s expected %h got %h", name, want, got);
            abort_run();
        end
    endtask

    // returns {rc4, rc3, pxl}
    function automatic logic [9:0] ref_pixel(
        input logic [11:0] i0, input logic [11:0] i1,
        input logic [11:0] c0, input logic [11:0] c1,
        input road_pkg::road_mode_t md,
        input logic [1:0] pa, input logic [1:0] pb,
        input logic ca, input logic cb
    );
        logic a_bl, b_bl, a_ed, b_ed, nr, nrb, sel, ed;
        logic [1:0] ps, sp;
        logic [11:0] c;
        logic [7:0] p;
        a_bl = !ca && pa == 2'd3;
        b_bl = !cb && pb == 2'd3;
        a_ed = ca && pa == 2'd3;
        b_ed = cb && pb == 2'd3;
        nr = (i0[11] && i1[11]) || (i0[11] && md == road_pkg::ONLY_ROAD0) ||
             (i1[11] && md == road_pkg::ONLY_ROAD1);
        case (md)
            road_pkg::ONLY_ROAD0: begin
                nrb = nr || a_bl;
                sel = 1'b0;
            end
            road_pkg::ONLY_ROAD1: begin
                nrb = nr || b_bl;
                sel = 1'b1;
            end
            // road 1 on top unless it shows plain road over a coloured road 0
            road_pkg::ROAD1_PRIO: begin
                nrb = nr || (a_bl && b_bl);
                sel = b_ed || a_bl || (pb == 2'd0 && pa != 2'd3);
            end
            default: begin
                nrb = nr || (a_bl && b_bl);
                sel = (a_bl && (b_ed || pb == 2'd1 || pb == 2'd2)) ||
                      (!ca && pa != 2'd0 && pb == 2'd0) || (b_ed && pa != 2'd3);
            end
        endcase
        ps = sel ? pb : pa;
        ed = sel ? b_ed : a_ed;
        sp = ed ? 2'b11 : (ps == 2'd1 ? 2'b01 : (ps == 2'd2 ? 2'b10 : 2'b00));
        c = sel ? c1 : c0;
        if (!nrb) begin
            p = {4'd0, sel, sp, c[{sel, sp}]};
        end else if (nr) begin
            p = {1'b1, sel ? i0[6:0] : i1[6:0]};
        end else begin
            p = {3'b001, sel, c[11:8]};
        end
        return {nrb, nr, p};
    endfunction

    // compare the strobe just taken, then model the next one
    always @(negedge clk) begin
        logic en;
        if (pend) begin
            check_pixel(pend_exp[7:0], pxl);
            check_rc(pend_exp[9:8], rc);
            if (e_idx[0][11] && e_idx[1][11]) begin
                check_rc(2'b11, rc);
            end
            pend = 1'b0;
        end
        if (line_on && hs) begin
            for (int r = 0; r < 2; r++) begin
                m_pos[r]  = e_scr[r];
                m_sh[r]   = 16'hffff;
                m_cent[r] = 1'b0;
                m_cs[r]   = 1'b0;
            end
        end else if (line_on && pxl_cen) begin
            pend_exp = ref_pixel(e_idx[0], e_idx[1], e_col[0], e_col[1], e_mode,
                                 {m_sh[0][15], m_sh[0][7]}, {m_sh[1][15], m_sh[1][7]},
                                 m_cent[0], m_cent[1]);
            pend = 1'b1;
            check_addr("rom0_addr", {e_idx[0][8:1], m_pos[0][8:3]}, rom0_addr);
            check_addr("rom1_addr", {e_idx[1][8:1], m_pos[1][8:3]}, rom1_addr);
            check_flag("rom0_cs", m_cs[0], rom0_cs);
            check_flag("rom1_cs", m_cs[1], rom1_cs);
            for (int r = 0; r < 2; r++) begin
                en = !e_idx[r][11] && m_pos[r][11:9] == 3'd3;
                m_cs[r] = en;
                if (m_pos[r][2:0] == 3'd0) begin
                    m_sh[r] = en ? (r == 0 ? rom0_data : rom1_data) : 16'hffff;
                end else begin
                    m_sh[r] = m_sh[r] << 1;
                end
                if (m_pos[r][11:9] != 3'd3 || m_pos[r][8:0] == 9'h0ff) begin
                    m_cent[r] = 1'b1;
                end
                m_pos[r] = m_pos[r] + 12'd1;
            end
        end
    end

    task automatic wait_strobes(input int n);
        repeat (n) begin
            @(posedge clk);
            while (!pxl_cen) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic cpu_write(input logic [10:0] a, input logic [15:0] d, input logic [1:0] dswn);
        @(posedge clk);
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_dswn <= dswn;
        road_cs  <= 1'b1;
        @(posedge clk);
        road_cs  <= 1'b0;
        cpu_dswn <= 2'b11;
    endtask

    task automatic io_write(input logic [15:0] d, input logic [1:0] dswn);
        @(posedge clk);
        cpu_dout <= d;
        cpu_dswn <= dswn;
        io_cs    <= 1'b1;
        @(posedge clk);
        io_cs    <= 1'b0;
        cpu_dswn <= 2'b11;
    endtask

    // data is due one clk after the address
    task automatic cpu_read(input logic [10:0] a, output logic [15:0] d);
        @(posedge clk);
        cpu_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = cpu_din;
    endtask

    task automatic swap_halves();
        io_write(16'h0000, 2'b11);
        @(posedge clk);
        vint <= 1'b1;
        @(posedge clk);
        vint <= 1'b0;
        half_exp = ~half_exp;
        @(negedge clk);
        check_flag("ram_half", half_exp, ram_half);
    endtask

    task automatic setup_line(input logic [8:0] line, input logic [11:0] i0, input logic [11:0] i1,
                              input logic [11:0] s0, input logic [11:0] s1,
                              input logic [11:0] c0, input logic [11:0] c1,
                              input road_pkg::road_mode_t md);
        cpu_write({3'd0, line[7:0]}, {4'ha, i0}, 2'b00);
        cpu_write({3'd1, line[7:0]}, {4'ha, i1}, 2'b00);
        cpu_write({2'd1, i0[8:0]}, {4'h5, s0}, 2'b00);
        cpu_write({2'd2, i1[8:0]}, {4'h5, s1}, 2'b00);
        cpu_write({2'd3, i0[8:0]}, {4'hc, c0}, 2'b00);
        cpu_write({2'd3, i1[8:0]}, {4'hc, c1}, 2'b00);
        swap_halves();
        io_write({14'd0, md}, 2'b10);
        e_idx[0] = i0;
        e_idx[1] = i1;
        e_scr[0] = s0;
        e_scr[1] = s1;
        e_col[0] = c0;
        e_col[1] = c1;
        e_mode   = md;
    endtask

    task automatic run_line(input logic [8:0] line);
        @(posedge clk);
        v <= line;
        wait_strobes(2);
        hs <= 1'b1;
        line_on = 1'b1;
        wait_strobes(HS_PX);
        hs <= 1'b0;
        wait_strobes(LINE_PX);
        line_on = 1'b0;
    endtask

    // scroll lands just before the road window so both edges are crossed
    task automatic random_line(input logic [8:0] line, input road_pkg::road_mode_t md,
                               input logic non_rom);
        logic [31:0] r0, r1, r2;
        logic [11:0] i0, i1;
        r0 = $urandom;
        r1 = $urandom;
        r2 = $urandom;
        i0 = {non_rom || r0[31:30] == 2'd0, r0[10:0]};
        i1 = {non_rom || r1[31:30] == 2'd0, r1[10:9], i0[8:0] ^ {1'b1, r1[7:0]}};
        setup_line(line, i0, i1, 12'h580 + {4'd0, r2[7:0]}, 12'h580 + {4'd0, r2[15:8]},
                   r0[27:16], r1[27:16], md);
        run_line(line);
    endtask

    initial begin
        #(WD_NS);
        $display("timeout: the road test did not finish within %0d ns", WD_NS);
        abort_run();
    end

    initial begin
        logic [31:0] r;
        logic [15:0] shadow, got;
        void'($urandom(63));
        rst      = 1'b1;
        v        = 9'd0;
        vint     = 1'b0;
        hs       = 1'b0;
        cpu_addr = '0;
        cpu_dout = 16'h0000;
        cpu_dswn = 2'b11;
        road_cs  = 1'b0;
        io_cs    = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // byte strobe merging on the CPU port
        shadow = 16'h0000;
        cpu_write(11'h7f0, shadow, 2'b00);
        for (int k = 0; k < 4; k++) begin
            r = $urandom;
            cpu_write(11'h7f0, r[15:0], 2'(k));
            shadow = {k[1] ? shadow[15:8] : r[15:8], k[0] ? shadow[7:0] : r[7:0]};
            cpu_read(11'h7f0, got);
            check_word(shadow, got);
        end

        // each half keeps its own copy across swaps
        cpu_write(11'h7f8, 16'h5aa5, 2'b00);
        swap_halves();
        cpu_write(11'h7f8, 16'hc33c, 2'b00);
        cpu_read(11'h7f8, got);
        check_word(16'hc33c, got);
        swap_halves();
        cpu_read(11'h7f8, got);
        check_word(16'h5aa5, got);
        swap_halves();
        cpu_read(11'h7f8, got);
        check_word(16'hc33c, got);

        random_line(9'd17, road_pkg::ROAD0_PRIO, 1'b1);
        random_line(9'd18, road_pkg::ONLY_ROAD1, 1'b1);
        for (int m = 0; m < 4; m++) begin
            for (int n = 0; n < 3; n++) begin
                random_line(9'(40 + m * 3 + n), road_pkg::road_mode_t'(m[1:0]), 1'b0);
            end
        end

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: tb/road_rom_model.sv
`timescale 1ns/1ps

module road_rom_model (
    input  logic        clk,
    input  logic [13:0] addr,
    input  logic        cs,
    output logic [15:0] data,
    output logic        ok
);

    logic [15:0] mixed;
    logic [15:0] data_q = 16'h0000;
    logic        ok_q = 1'b0;

    // every address bit reaches the data word
    assign mixed = {2'b00, addr} ^ 16'h9c35;

    // answers one clk after the address, whether selected or not
    always @(posedge clk) begin
        data_q <= {mixed[10:0], mixed[15:11]} ^ (mixed >> 3);
        ok_q   <= cs;
    end

    assign data = data_q;
    assign ok   = ok_q;

endmodule

// File: rtl/road_top.sv
`timescale 1ns/1ps

module road_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic [ 8:0] v,
    input  logic        vint,
    input  logic        hs,

    // CPU side
    input  logic [11:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    output logic [15:0] cpu_din,
    input  logic [ 1:0] cpu_dswn,
    input  logic        road_cs,
    input  logic        io_cs,
    output logic        ram_half,

    // graphics ROM, one port per road
    output logic [13:0] rom0_addr,
    input  logic [15:0] rom0_data,
    output logic        rom0_cs,
    input  logic        rom0_ok,
    output logic [13:0] rom1_addr,
    input  logic [15:0] rom1_data,
    output logic        rom1_cs,
    input  logic        rom1_ok,

    output logic [ 7:0] pxl,
    output logic [ 4:3] rc
);

    logic [road_pkg::RAM_AW-2:0] rd_addr;
    logic [15:0] rd_gfx;
    logic [road_pkg::DESC_W-1:0] idx0, idx1, scr0, scr1, col0, col1;
    logic [ 1:0] pxl_a, pxl_b;
    logic        cent_a, cent_b;

    road_ram u_ram (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .vint     ( vint     ),
        .io_cs    ( io_cs    ),
        .road_cs  ( road_cs  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_dswn ( cpu_dswn ),
        .rd_addr  ( rd_addr  ),
        .cpu_din  ( cpu_din  ),
        .rd_gfx   ( rd_gfx   ),
        .ram_half ( ram_half )
    );

    road_line_seq u_seq (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .hs      ( hs      ),
        .v       ( v       ),
        .rd_gfx  ( rd_gfx  ),
        .rd_addr ( rd_addr ),
        .idx0    ( idx0    ),
        .idx1    ( idx1    ),
        .scr0    ( scr0    ),
        .scr1    ( scr1    ),
        .col0    ( col0    ),
        .col1    ( col1    )
    );

    road_rom_shifter u_rom0 (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .pxl_cen  ( pxl_cen   ),
        .hs       ( hs        ),
        .cfg      ( idx0      ),
        .hscr     ( scr0      ),
        .rom_data ( rom0_data ),
        .rom_ok   ( rom0_ok   ),
        .rom_addr ( rom0_addr ),
        .rom_cs   ( rom0_cs   ),
        .cent     ( cent_a    ),
        .pxl      ( pxl_a     )
    );

    road_rom_shifter u_rom1 (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .pxl_cen  ( pxl_cen   ),
        .hs       ( hs        ),
        .cfg      ( idx1      ),
        .hscr     ( scr1      ),
        .rom_data ( rom1_data ),
        .rom_ok   ( rom1_ok   ),
        .rom_addr ( rom1_addr ),
        .rom_cs   ( rom1_cs   ),
        .cent     ( cent_b    ),
        .pxl      ( pxl_b     )
    );

    road_mixer u_mixer (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .hs       ( hs       ),
        .io_cs    ( io_cs    ),
        .cpu_dout ( cpu_dout ),
        .cpu_dswn ( cpu_dswn ),
        .idx0     ( idx0     ),
        .idx1     ( idx1     ),
        .col0     ( col0     ),
        .col1     ( col1     ),
        .pxl_a    ( pxl_a    ),
        .pxl_b    ( pxl_b    ),
        .cent_a   ( cent_a   ),
        .cent_b   ( cent_b   ),
        .pxl      ( pxl      ),
        .rc       ( rc       )
    );

endmodule

// File: rtl/road_mixer.sv
`timescale 1ns/1ps

module road_mixer (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        hs,
    input  logic        io_cs,
    input  logic [15:0] cpu_dout,
    input  logic [ 1:0] cpu_dswn,
    input  logic [11:0] idx0,
    input  logic [11:0] idx1,
    input  logic [11:0] col0,
    input  logic [11:0] col1,
    input  logic [ 1:0] pxl_a,
    input  logic [ 1:0] pxl_b,
    input  logic        cent_a,
    input  logic        cent_b,
    output logic [ 7:0] pxl,
    output logic [ 4:3] rc
);

    road_pkg::road_mode_t mode;
    logic only0, only1, r0_prio, r1_prio;
    logic a_blank, b_blank, a_edge, b_edge;
    logic not_rom, not_rom_blank;
    logic rd_sel;
    logic [1:0] stripe;
    logic [road_pkg::DESC_W-1:0] col_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= road_pkg::ONLY_ROAD0;
        end else if (io_cs && !cpu_dswn[0]) begin
            mode <= road_pkg::road_mode_t'(cpu_dout[1:0]);
        end
    end

    assign only0   = mode == road_pkg::ONLY_ROAD0;
    assign only1   = mode == road_pkg::ONLY_ROAD1;
    assign r0_prio = mode == road_pkg::ROAD0_PRIO;
    assign r1_prio = mode == road_pkg::ROAD1_PRIO;

    // pixel 3 is blank inside the road and the edge colour outside it
    assign a_blank = !cent_a && pxl_a == 2'd3;
    assign b_blank = !cent_b && pxl_b == 2'd3;
    assign a_edge  = cent_a && pxl_a == 2'd3;
    assign b_edge  = cent_b && pxl_b == 2'd3;

    always_comb begin
        not_rom = (idx0[11] && idx1[11]) || (idx0[11] && only0) || (idx1[11] && only1);
        not_rom_blank = not_rom || (a_blank && b_blank) || (b_blank && only1) ||
                        (a_blank && only0);
        // high picks road 1
        rd_sel = (hs && !not_rom_blank) || only1 ||
                 (a_blank && b_blank && r1_prio) ||
                 (a_blank && b_edge && r0_prio) ||
                 (a_blank && pxl_b == 2'd1 && r0_prio) ||
                 (a_blank && pxl_b == 2'd2 && r0_prio) ||
                 (a_blank && !pxl_b[0] && r1_prio) ||
                 (a_blank && !pxl_b[1] && r1_prio) ||
                 (!cent_a && pxl_a[0] && pxl_b == 2'd0 && r0_prio) ||
                 (!cent_a && pxl_a[1] && pxl_b == 2'd0 && r0_prio) ||
                 (b_edge && r1_prio) ||
                 (b_edge && !pxl_a[0] && r0_prio) ||
                 (b_edge && !pxl_a[1] && r0_prio) ||
                 (!pxl_a[0] && pxl_b == 2'd0 && r1_prio) ||
                 (!pxl_a[1] && pxl_b == 2'd0 && r1_prio);
        if (rd_sel) begin
            stripe[0] = pxl_b == 2'd1 || b_edge;
            stripe[1] = pxl_b == 2'd2 || b_edge;
        end else begin
            stripe[0] = pxl_a == 2'd1 || a_edge;
            stripe[1] = pxl_a == 2'd2 || a_edge;
        end
        col_sel = rd_sel ? col1 : col0;
    end

    // one pixel strobe behind the shifters
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (!not_rom_blank) begin
                pxl <= {4'd0, rd_sel, stripe, col_sel[{1'b0, rd_sel, stripe}]};
            end else if (not_rom) begin
                pxl <= {1'b1, rd_sel ? idx0[6:0] : idx1[6:0]};
            end else begin
                pxl <= {3'b001, rd_sel, col_sel[11:8]};
            end
            rc <= {not_rom_blank, not_rom};
        end
    end

endmodule

// File: rtl/road_rom_shifter.sv
`timescale 1ns/1ps

module road_rom_shifter (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        hs,
    input  logic [11:0] cfg,
    input  logic [11:0] hscr,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    output logic [13:0] rom_addr,
    output logic        rom_cs,
    output logic        cent,
    output logic [ 1:0] pxl
);

    logic [road_pkg::DESC_W-1:0] hpos;
    logic [15:0] pxl_data;
    logic        en;
    logic        in_win;

    // two bit planes, one per byte
    assign pxl      = {pxl_data[15], pxl_data[7]};
    assign in_win   = hpos[11:9] == 3'b011;
    assign en       = !cfg[11] && in_win;
    assign rom_addr = {cfg[8:1], hpos[8:3]};

    // rom_ok is not waited on, the board samples rom_data on the 8 pixel boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs <= 1'b0;
            hpos   <= '0;
            cent   <= 1'b0;
        end else begin
            if (hs) begin
                rom_cs <= 1'b0;
                hpos   <= hscr;
                cent   <= 1'b0;
            end else if (pxl_cen) begin
                rom_cs <= en;
                hpos   <= hpos + 12'd1;
                // past the road or at its last column
                if (!in_win || hpos[8:0] == 9'h0ff) begin
                    cent <= 1'b1;
                end
            end
        end
    end

    // pixel shifter, all ones reads as blank road
    always_ff @(posedge clk) begin
        if (hs) begin
            pxl_data <= 16'hffff;
        end else if (pxl_cen) begin
            if (hpos[2:0] == 3'd0) begin
                pxl_data <= en ? rom_data : 16'hffff;
            end else begin
                pxl_data <= pxl_data << 1;
            end
        end
    end

    // the ROM needs a clk to answer between two strobes
    a_cen_gap: assert property (@(posedge clk) disable iff (rst) pxl_cen |=> !pxl_cen);

endmodule

// File: rtl/road_line_seq.sv
`timescale 1ns/1ps

module road_line_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        hs,
    input  logic [ 8:0] v,
    input  logic [15:0] rd_gfx,
    output logic [10:0] rd_addr,
    output logic [11:0] idx0,
    output logic [11:0] idx1,
    output logic [11:0] scr0,
    output logic [11:0] scr1,
    output logic [11:0] col0,
    output logic [11:0] col1
);

    road_pkg::fetch_st_t st;
    logic [road_pkg::DESC_W-1:0] desc_word;

    assign desc_word = rd_gfx[road_pkg::DESC_W-1:0];

    // word address for the current step
    // index table is 256 lines per road, the rest is indexed by the road index
    always_comb begin
        case (st)
            road_pkg::FETCH_IDX0: rd_addr = {3'd0, v[7:0]};
            road_pkg::FETCH_IDX1: rd_addr = {3'd1, v[7:0]};
            road_pkg::FETCH_SCR0: rd_addr = {2'd1, idx0[8:0]};
            road_pkg::FETCH_SCR1: rd_addr = {2'd2, idx1[8:0]};
            road_pkg::FETCH_COL0: rd_addr = {2'd3, idx0[8:0]};
            default:              rd_addr = {2'd3, idx1[8:0]};
        endcase
    end

    // one word per pixel strobe while in blank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= road_pkg::FETCH_IDX0;
            idx0 <= '0;
            idx1 <= '0;
            scr0 <= '0;
            scr1 <= '0;
            col0 <= '0;
            col1 <= '0;
        end else if (pxl_cen) begin
            if (hs) begin
                case (st)
                    road_pkg::FETCH_IDX0: begin
                        idx0 <= desc_word;
                        st   <= road_pkg::FETCH_IDX1;
                    end
                    road_pkg::FETCH_IDX1: begin
                        idx1 <= desc_word;
                        st   <= road_pkg::FETCH_SCR0;
                    end
                    road_pkg::FETCH_SCR0: begin
                        scr0 <= desc_word;
                        st   <= road_pkg::FETCH_SCR1;
                    end
                    road_pkg::FETCH_SCR1: begin
                        scr1 <= desc_word;
                        st   <= road_pkg::FETCH_COL0;
                    end
                    road_pkg::FETCH_COL0: begin
                        col0 <= desc_word;
                        st   <= road_pkg::FETCH_COL1;
                    end
                    road_pkg::FETCH_COL1: begin
                        col1 <= desc_word;
                        st   <= road_pkg::FETCH_DONE;
                    end
                    default: st <= road_pkg::FETCH_DONE;
                endcase
            end else begin
                st <= road_pkg::FETCH_IDX0;
            end
        end
    end

    // blank must last long enough to latch all six words
    a_fetch_done: assert property (@(posedge clk) disable iff (rst)
        $fell(hs) |-> st == road_pkg::FETCH_DONE);

endmodule

// File: rtl/road_ram.sv
`timescale 1ns/1ps

module road_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic        vint,
    input  logic        io_cs,
    input  logic        road_cs,
    input  logic [11:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [ 1:0] cpu_dswn,
    input  logic [10:0] rd_addr,
    output logic [15:0] cpu_din,
    output logic [15:0] rd_gfx,
    output logic        ram_half
);

    logic [15:0] mem [0:2**road_pkg::RAM_AW-1];
    logic [road_pkg::RAM_AW-1:0] cpu_a;
    logic [road_pkg::RAM_AW-1:0] gfx_a;
    logic [1:0] we;
    logic       swap_arm;

    // CPU sees the half the road engine is not drawing from
    assign cpu_a = {~ram_half, cpu_addr};
    assign gfx_a = {ram_half, rd_addr};
    assign we    = {2{road_cs}} & ~cpu_dswn;

    // swap is armed by an io access with no byte strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_half <= 1'b0;
            swap_arm <= 1'b0;
        end else begin
            if (vint && swap_arm) begin
                ram_half <= ~ram_half;
                swap_arm <= 1'b0;
            end else if (io_cs && cpu_dswn == 2'b11) begin
                swap_arm <= 1'b1;
            end
        end
    end

    // CPU port, byte writes and registered read
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[cpu_a][7:0] <= cpu_dout[7:0];
        end
        if (we[1]) begin
            mem[cpu_a][15:8] <= cpu_dout[15:8];
        end
        cpu_din <= mem[cpu_a];
    end

    // road engine port, read only
    always_ff @(posedge clk) begin
        rd_gfx <= mem[gfx_a];
    end

    // the CPU map decodes the two selects apart
    a_cs_excl: assert property (@(posedge clk) disable iff (rst) !(road_cs && io_cs));

endmodule

// File: rtl/road_pkg.sv
package road_pkg;

    // descriptor word as kept by the line sequencer
    localparam int DESC_W = 12;

    // road RAM word address, top bit picks the half
    localparam int RAM_AW = 12;

    // graphics ROM word address
    localparam int ROM_AW = 14;

    // road priority mode written through the io select
    typedef enum logic [1:0] {
        ONLY_ROAD0 = 2'd0,
        ROAD0_PRIO = 2'd1,
        ROAD1_PRIO = 2'd2,
        ONLY_ROAD1 = 2'd3
    } road_mode_t;

    // descriptor fetch steps during horizontal blank
    typedef enum logic [2:0] {
        FETCH_IDX0 = 3'd0,
        FETCH_IDX1 = 3'd1,
        FETCH_SCR0 = 3'd2,
        FETCH_SCR1 = 3'd3,
        FETCH_COL0 = 3'd4,
        FETCH_COL1 = 3'd5,
        FETCH_DONE = 3'd6
    } fetch_st_t;

endpackage
